// ==== i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

   // ------------------------------------------------------------------------
   // bus constants
   // ------------------------------------------------------------------------
   localparam logic [6:0] TARGET_ADDR = 7'h55;  // seven-bit device address
   localparam int         BYTE_BITS   = 8;      // data bits per byte
   localparam int         ACK_SLOT    = 8;      // ninth slot carries the ack

   // transaction states
   typedef enum logic [2:0] {
      st_idle,
      st_dev_addr,
      st_addr_ack,
      st_index,
      st_write,
      st_read
   } i2c_state_e;

   // one-cycle event pulses plus the synchronized data level
   typedef struct packed {
      logic scl_rise;
      logic scl_fall;
      logic start;
      logic stop;
      logic sda;
   } bus_events_t;

endpackage

`default_nettype wire

// ==== regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

   localparam int REG_IDX_W = 8;  // index pointer width

   // ------------------------------------------------------------------------
   // register indices
   // ------------------------------------------------------------------------
   localparam logic [REG_IDX_W-1:0] IDX_CFG_LAST   = 8'd13;  // last settings byte
   localparam logic [REG_IDX_W-1:0] IDX_CONTROL_LO = 8'd18;  // write side
   localparam logic [REG_IDX_W-1:0] IDX_CLEAR      = 8'd20;
   localparam logic [REG_IDX_W-1:0] IDX_ADC_LO     = 8'd18;  // read side
   localparam logic [REG_IDX_W-1:0] IDX_STATUS     = 8'd20;
   localparam logic [REG_IDX_W-1:0] IDX_MONITOR    = 8'd21;

   localparam logic [7:0] READ_FILL        = 8'hFE;  // unmapped read value
   localparam int         CTRL_HOLD_CYCLES = 5;      // control word lifetime

   // settings and control seen by the driver board
   typedef struct packed {
      logic [15:0] dds_control;
      logic [15:0] dds_gain;
      logic [15:0] cw_gain;
      logic [15:0] dds_current_limit;
      logic [15:0] cw_current_limit;
      logic [15:0] dds_mon_current_limit;
      logic [15:0] cw_mon_current_limit;
      logic [15:0] control;
      logic        clear;
   } cfg_regs_t;

   // read-only values from the board
   typedef struct packed {
      logic [15:0] adc_data_value;
      logic [7:0]  status;
      logic [7:0]  monitor_status;
   } sense_t;

   // single byte write toward the register file
   typedef struct packed {
      logic                 strobe;
      logic [REG_IDX_W-1:0] index;
      logic [7:0]           data;
   } reg_wr_t;

endpackage

`default_nettype wire

// ==== i2c_bus_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_sampler (
   input  logic                 RST,
   input  logic                 SCL,
   input  logic                 i2c_scl,
   input  logic                 i2c_sda,
   output i2c_pkg::bus_events_t events
);

   logic [1:0] scl_sync;  // two-flop synchronizers
   logic [1:0] sda_sync;
   logic       scl_prev;  // previous synchronized levels
   logic       sda_prev;

   // ------------------------------------------------------------------------
   // synchronize the pins, then register edge and start/stop pulses
   // ------------------------------------------------------------------------
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL) begin
         scl_sync <= 2'b11;  // bus idles high
         sda_sync <= 2'b11;
         scl_prev <= 1'b1;
         sda_prev <= 1'b1;
         events   <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0,
                       sda: 1'b1};
      end else begin
         scl_sync <= {scl_sync[0], i2c_scl};
         sda_sync <= {sda_sync[0], i2c_sda};
         scl_prev <= scl_sync[1];
         sda_prev <= sda_sync[1];

         events.scl_rise <= scl_sync[1] & ~scl_prev;
         events.scl_fall <= ~scl_sync[1] & scl_prev;
         // sda moving while scl stays high
         events.start    <= scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
         events.stop     <= scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];
         events.sda      <= sda_sync[1];  // aligned with the pulses
      end
   end

endmodule

`default_nettype wire

// ==== i2c_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_counter (
   input  logic                 RST,
   input  logic                 SCL,
   input  i2c_pkg::bus_events_t events,
   output logic                 last_bit,
   output logic                 ack_slot
);

   import i2c_pkg::*;

   logic [3:0] slot_cnt;  // position within the nine-bit slot

   // start parks the count at all ones so the start's own scl fall
   // wraps it to zero, ready for the first data bit
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL) begin
         slot_cnt <= 4'hf;
      end else if (events.start) begin
         slot_cnt <= 4'hf;
      end else if (events.scl_fall) begin
         if (ack_slot)
            slot_cnt <= '0;  // byte slot finished
         else
            slot_cnt <= slot_cnt + 4'd1;
      end
   end

   assign last_bit = (slot_cnt == 4'(BYTE_BITS - 1));
   assign ack_slot = (slot_cnt == 4'(ACK_SLOT));

endmodule

`default_nettype wire

// ==== i2c_byte_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shifter (
   input  logic                 RST,
   input  logic                 SCL,
   input  i2c_pkg::bus_events_t events,
   input  logic                 ack_slot,
   input  logic                 tx_load,
   input  logic [7:0]           tx_byte,
   output logic [7:0]           rx_byte,
   output logic                 tx_bit
);

   logic [7:0] tx_q;  // msb is on the wire

   // ------------------------------------------------------------------------
   // receive, msb first, sampled on the rising clock edge
   // ------------------------------------------------------------------------
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL)
         rx_byte <= '0;
      else if (events.stop)
         rx_byte <= '0;
      else if (events.scl_rise && !ack_slot)
         rx_byte <= {rx_byte[6:0], events.sda};
   end

   // ------------------------------------------------------------------------
   // transmit, next bit moves up on each falling edge
   // ------------------------------------------------------------------------
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL)
         tx_q <= 8'hff;
      else if (tx_load)
         tx_q <= tx_byte;
      else if (events.scl_fall && !ack_slot)
         tx_q <= {tx_q[6:0], 1'b1};  // ones shift in, line released
   end

   assign tx_bit = tx_q[7];

endmodule

`default_nettype wire

// ==== i2c_target_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_target_fsm (
   input  logic                 RST,
   input  logic                 SCL,
   input  i2c_pkg::bus_events_t events,
   input  logic                 last_bit,
   input  logic                 ack_slot,
   input  logic [7:0]           rx_byte,
   output regmap_pkg::reg_wr_t  wr,
   output logic [7:0]           rd_index,
   output logic                 tx_load,
   input  logic                 tx_bit,
   output logic                 sda_oe,
   output logic                 read_busy
);

   import i2c_pkg::*;
   import regmap_pkg::*;

   i2c_state_e           state;
   logic [REG_IDX_W-1:0] ptr;        // register index pointer
   logic                 rd_mode;    // r/w bit of the address byte
   logic                 ack_drive;  // we acknowledge this slot
   logic                 tx_phase;   // read data on the line
   logic                 byte_done;
   logic                 slot_done;
   logic                 ack_seen;

   assign byte_done = events.scl_fall & last_bit;  // into the ack slot
   assign slot_done = events.scl_fall & ack_slot;  // out of the ack slot
   assign ack_seen  = events.scl_rise & ack_slot;  // master's ack sampled

   always_ff @(posedge RST or posedge SCL) begin
      if (SCL) begin
         state     <= st_idle;
         ptr       <= '0;
         rd_mode   <= 1'b0;
         ack_drive <= 1'b0;
         tx_phase  <= 1'b0;
         tx_load   <= 1'b0;
         read_busy <= 1'b0;
         wr        <= '0;
      end else begin
         tx_load   <= 1'b0;
         wr.strobe <= 1'b0;
         if (events.stop || events.start) begin
            state     <= events.stop ? st_idle : st_dev_addr;
            ack_drive <= 1'b0;
            tx_phase  <= 1'b0;
            read_busy <= 1'b0;
         end else begin
            case (state)
               st_dev_addr: if (byte_done) begin
                  if (rx_byte[7:1] == TARGET_ADDR) begin
                     state     <= st_addr_ack;
                     ack_drive <= 1'b1;
                     rd_mode   <= rx_byte[0];
                     tx_load   <= rx_byte[0];  // first read byte at the pointer
                     read_busy <= rx_byte[0];
                  end else begin
                     state <= st_idle;  // not us, stay off the bus
                  end
               end
               st_addr_ack: if (slot_done) begin
                  ack_drive <= 1'b0;
                  state     <= rd_mode ? st_read : st_index;
                  tx_phase  <= rd_mode;
               end
               st_index: begin
                  if (byte_done) begin
                     ack_drive <= 1'b1;
                     ptr       <= rx_byte;
                  end else if (slot_done) begin
                     ack_drive <= 1'b0;
                     state     <= st_write;
                  end
               end
               st_write: begin
                  if (byte_done) begin
                     ack_drive <= 1'b1;
                  end else if (slot_done) begin
                     ack_drive <= 1'b0;
                     wr.strobe <= 1'b1;
                     wr.index  <= ptr;
                     wr.data   <= rx_byte;
                     ptr       <= ptr + 1'b1;  // auto-increment
                  end
               end
               st_read: begin
                  if (byte_done) begin
                     tx_phase <= 1'b0;  // let the master ack
                  end else if (ack_seen) begin
                     if (events.sda) begin
                        state     <= st_idle;  // nack ends the read
                        read_busy <= 1'b0;
                     end else begin
                        ptr     <= ptr + 1'b1;
                        tx_load <= 1'b1;
                     end
                  end else if (slot_done) begin
                     tx_phase <= 1'b1;
                  end
               end
               default: ;  // idle, waits for a start
            endcase
         end
      end
   end

   assign rd_index = ptr;
   assign sda_oe   = ack_drive | (tx_phase & ~tx_bit);

endmodule

`default_nettype wire

// ==== ctrl_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regfile (
   input  logic                  RST,
   input  logic                  SCL,
   input  regmap_pkg::reg_wr_t   wr,
   input  logic [7:0]            rd_index,
   input  regmap_pkg::sense_t    sense,
   output logic [7:0]            rd_data,
   output regmap_pkg::cfg_regs_t cfg
);

   import regmap_pkg::*;

   localparam int HOLD_W = $clog2(CTRL_HOLD_CYCLES + 1);

   logic [IDX_CFG_LAST:0][7:0] set_q;      // settings bytes, low at even index
   logic [15:0]                control_q;
   logic                       clear_q;
   logic [HOLD_W-1:0]          hold_cnt;   // cycles control has been nonzero
   logic                       hold_done;

   assign hold_done = (hold_cnt == HOLD_W'(CTRL_HOLD_CYCLES));

   // ------------------------------------------------------------------------
   // settings bytes 0..13
   // ------------------------------------------------------------------------
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL)
         set_q <= '0;
      else if (wr.strobe && (wr.index <= IDX_CFG_LAST))
         set_q[wr.index[3:0]] <= wr.data;
   end

   // ------------------------------------------------------------------------
   // control word with auto-clear, and the clear level
   // ------------------------------------------------------------------------
   always_ff @(posedge RST or posedge SCL) begin
      if (SCL) begin
         control_q <= '0;
         clear_q   <= 1'b0;
         hold_cnt  <= '0;
      end else begin
         if (control_q == '0) begin
            hold_cnt <= '0;
         end else if (hold_done) begin
            hold_cnt  <= '0;
            control_q <= '0;  // one-shot command expires
         end else begin
            hold_cnt <= hold_cnt + 1'b1;
         end
         // a write in the same cycle wins
         if (wr.strobe) begin
            case (wr.index)
               IDX_CONTROL_LO:        control_q[7:0]  <= wr.data;
               IDX_CONTROL_LO + 8'd1: control_q[15:8] <= wr.data;
               IDX_CLEAR:             clear_q         <= wr.data[0];
               default: ;  // spare or read-only index
            endcase
         end
      end
   end

   // read side
   always_comb begin
      if (rd_index <= IDX_CFG_LAST) begin
         rd_data = set_q[rd_index[3:0]];
      end else begin
         case (rd_index)
            IDX_ADC_LO:        rd_data = sense.adc_data_value[7:0];
            IDX_ADC_LO + 8'd1: rd_data = sense.adc_data_value[15:8];
            IDX_STATUS:        rd_data = sense.status;
            IDX_MONITOR:       rd_data = sense.monitor_status;
            default:           rd_data = READ_FILL;
         endcase
      end
   end

   assign cfg.dds_control           = {set_q[1], set_q[0]};
   assign cfg.dds_gain              = {set_q[3], set_q[2]};
   assign cfg.cw_gain               = {set_q[5], set_q[4]};
   assign cfg.dds_current_limit     = {set_q[7], set_q[6]};
   assign cfg.cw_current_limit      = {set_q[9], set_q[8]};
   assign cfg.dds_mon_current_limit = {set_q[11], set_q[10]};
   assign cfg.cw_mon_current_limit  = {set_q[13], set_q[12]};
   assign cfg.control               = control_q;
   assign cfg.clear                 = clear_q;

endmodule

`default_nettype wire

// ==== openwater_i2c.sv ====
`timescale 1ns/1ps
`default_nettype none

module openwater_i2c (
   input  logic                  RST,
   input  logic                  SCL,
   input  logic                  i2c_scl,
   input  logic                  i2c_sda,
   output logic                  i2c_sda_oe,
   output logic                  i2c_read_busy,
   input  regmap_pkg::sense_t    sense,
   output regmap_pkg::cfg_regs_t cfg
);

   import i2c_pkg::*;
   import regmap_pkg::*;

   bus_events_t          events;
   logic                 last_bit;
   logic                 ack_slot;
   logic                 tx_load;
   logic                 tx_bit;
   logic [7:0]           rx_byte;
   logic [7:0]           rd_data;
   logic [REG_IDX_W-1:0] rd_index;
   reg_wr_t              wr;

   // ------------------------------------------------------------------------
   // bus side
   // ------------------------------------------------------------------------
   i2c_bus_sampler sampler_inst (
      .RST     (RST),
      .SCL     (SCL),
      .i2c_scl (i2c_scl),
      .i2c_sda (i2c_sda),
      .events  (events)
   );

   i2c_bit_counter counter_inst (
      .RST      (RST),
      .SCL      (SCL),
      .events   (events),
      .last_bit (last_bit),
      .ack_slot (ack_slot)
   );

   i2c_byte_shifter shifter_inst (
      .RST      (RST),
      .SCL      (SCL),
      .events   (events),
      .ack_slot (ack_slot),
      .tx_load  (tx_load),
      .tx_byte  (rd_data),
      .rx_byte  (rx_byte),
      .tx_bit   (tx_bit)
   );

   i2c_target_fsm fsm_inst (
      .RST       (RST),
      .SCL       (SCL),
      .events    (events),
      .last_bit  (last_bit),
      .ack_slot  (ack_slot),
      .rx_byte   (rx_byte),
      .wr        (wr),
      .rd_index  (rd_index),
      .tx_load   (tx_load),
      .tx_bit    (tx_bit),
      .sda_oe    (i2c_sda_oe),
      .read_busy (i2c_read_busy)
   );

   // register map
   ctrl_regfile regfile_inst (
      .RST      (RST),
      .SCL      (SCL),
      .wr       (wr),
      .rd_index (rd_index),
      .sense    (sense),
      .rd_data  (rd_data),
      .cfg      (cfg)
   );

endmodule

`default_nettype wire

// ==== tb_openwater_i2c_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_openwater_i2c_assert (
   input logic                RST,
   input logic                SCL,
   input i2c_pkg::i2c_state_e state,
   input logic                sda_oe,
   input logic                strobe,
   input logic                start,
   input logic                stop
);

   import i2c_pkg::*;

   // the target stays off the line outside a transaction
   idle_quiet: assert property (@(posedge RST) disable iff (SCL)
      (state == st_idle) |-> !sda_oe)
      else $error("sda_oe driven while the FSM is idle");

   strobe_pulse: assert property (@(posedge RST) disable iff (SCL)
      strobe |=> !strobe)  // one write per data byte
      else $error("register write strobe longer than one cycle");

   // a target pulling sda while scl is high fakes a start
   start_stop_released: assert property (@(posedge RST) disable iff (SCL)
      (start || stop) |-> !sda_oe)
      else $error("start or stop seen while the target drives sda");

endmodule

bind i2c_target_fsm tb_openwater_i2c_assert fsm_assert_inst (
   .RST    (RST),
   .SCL    (SCL),
   .state  (state),
   .sda_oe (sda_oe),
   .strobe (wr.strobe),
   .start  (events.start),
   .stop   (events.stop)
);

`default_nettype wire

// ==== tb_openwater_i2c.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_openwater_i2c;

   import i2c_pkg::*;
   import regmap_pkg::*;

   localparam int HALF       = 8;     // clocks per scl half period
   localparam int QUARTER    = 4;
   localparam int WAIT_LIMIT = 2000;  // clocks before a wait gives up
   localparam int NUM_ROWS   = 8;

   typedef enum logic [1:0] {op_write, op_read, op_ctrl} op_e;

   typedef struct packed {
      op_e         op;
      logic [6:0]  addr;
      logic [7:0]  index;
      logic [4:0]  len;
      logic        rnd;   // random write data
      logic        nack;  // address should be refused
      logic [31:0] data;  // fixed bytes, first one at [7:0]
   } row_t;

   logic       RST;
   logic       SCL;
   logic       scl_drv;
   logic       sda_drv;
   logic       i2c_sda;
   logic       i2c_sda_oe;
   logic       i2c_read_busy;
   sense_t     sense;
   cfg_regs_t  cfg;
   row_t       stim [0:NUM_ROWS-1];
   logic [7:0] set_m [0:13];  // expected settings bytes
   logic       clear_m;
   integer     seed = 43880;
   int         checks = 0;
   int         errors = 0;
   int         timeouts = 0;

   assign i2c_sda = sda_drv & ~i2c_sda_oe;  // open-drain wired-AND

   openwater_i2c openwater_i2c_inst (
      .RST           (RST),
      .SCL           (SCL),
      .i2c_scl       (scl_drv),
      .i2c_sda       (i2c_sda),
      .i2c_sda_oe    (i2c_sda_oe),
      .i2c_read_busy (i2c_read_busy),
      .sense         (sense),
      .cfg           (cfg)
   );

   initial begin
      RST = 1'b0;
      forever #50 RST = ~RST;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic wait_clocks(input int n);
      repeat (n) @(posedge RST);
   endtask

   // ------------------------------------------------------------------------
   // bus master, scl low for 8 clocks and high for 8
   // ------------------------------------------------------------------------
   task automatic bus_start();
      sda_drv <= 1'b0;  // falls while scl is high
      wait_clocks(HALF);
      scl_drv <= 1'b0;
      wait_clocks(QUARTER);
   endtask

   task automatic bus_stop();
      sda_drv <= 1'b0;
      wait_clocks(QUARTER);
      scl_drv <= 1'b1;
      wait_clocks(HALF);
      sda_drv <= 1'b1;  // rises while scl is high
      wait_clocks(HALF);
   endtask

   task automatic write_bit(input logic b);
      sda_drv <= b;
      wait_clocks(QUARTER);
      scl_drv <= 1'b1;
      wait_clocks(HALF);
      scl_drv <= 1'b0;
      wait_clocks(QUARTER);
   endtask

   task automatic read_bit(output logic b);
      sda_drv <= 1'b1;  // release the line
      wait_clocks(QUARTER);
      scl_drv <= 1'b1;
      wait_clocks(QUARTER);
      @(negedge RST);
      b = i2c_sda;      // middle of the high phase
      wait_clocks(QUARTER);
      scl_drv <= 1'b0;
      wait_clocks(QUARTER);
   endtask

   task automatic write_byte(input logic [7:0] data, output logic ack);
      int i;
      for (i = 7; i >= 0; i--)
         write_bit(data[i]);
      read_bit(ack);
   endtask

   task automatic read_byte(output logic [7:0] data);
      int i;
      for (i = 7; i >= 0; i--)
         read_bit(data[i]);
   endtask

   // ------------------------------------------------------------------------
   // register model
   // ------------------------------------------------------------------------
   task automatic model_write(input int idx, input logic [7:0] data);
      if (idx <= 13)
         set_m[idx] = data;
      else if (idx == 20)
         clear_m = data[0];
      // control bytes expire on their own, others are spare
   endtask

   function automatic logic [7:0] expected_read(input int idx);
      if (idx <= 13)
         return set_m[idx];
      case (idx)
         18:      return sense.adc_data_value[7:0];
         19:      return sense.adc_data_value[15:8];
         20:      return sense.status;
         21:      return sense.monitor_status;
         default: return 8'hFE;
      endcase
   endfunction

   task automatic check_cfg();
      check_value("cfg.dds_control", cfg.dds_control, {set_m[1], set_m[0]});
      check_value("cfg.dds_gain", cfg.dds_gain, {set_m[3], set_m[2]});
      check_value("cfg.cw_gain", cfg.cw_gain, {set_m[5], set_m[4]});
      check_value("cfg.dds_current_limit", cfg.dds_current_limit, {set_m[7], set_m[6]});
      check_value("cfg.cw_current_limit", cfg.cw_current_limit, {set_m[9], set_m[8]});
      check_value("cfg.dds_mon_current_limit", cfg.dds_mon_current_limit,
                  {set_m[11], set_m[10]});
      check_value("cfg.cw_mon_current_limit", cfg.cw_mon_current_limit,
                  {set_m[13], set_m[12]});
      check_value("cfg.control", cfg.control, 32'h0);
      check_value("cfg.clear", cfg.clear, clear_m);
   endtask

   // ------------------------------------------------------------------------
   // transactions
   // ------------------------------------------------------------------------
   task automatic write_op(input row_t row);
      logic       ack;
      logic [7:0] data;
      int         i;
      bus_start();
      write_byte({row.addr, 1'b0}, ack);
      check_value("i2c_sda address ack", ack, row.nack);
      if (!row.nack) begin
         write_byte(row.index, ack);
         check_value("i2c_sda index ack", ack, 1'b0);
         for (i = 0; i < row.len; i++) begin
            if (row.rnd)
               data = 8'($random(seed));
            else
               data = row.data[8*i +: 8];
            write_byte(data, ack);
            check_value("i2c_sda data ack", ack, 1'b0);
            model_write(row.index + i, data);
         end
      end
      bus_stop();
   endtask

   task automatic read_op(input row_t row);
      logic       ack;
      logic [7:0] data;
      int         i;
      int         t;
      // set the pointer first
      bus_start();
      write_byte({row.addr, 1'b0}, ack);
      check_value("i2c_sda address ack", ack, 1'b0);
      write_byte(row.index, ack);
      check_value("i2c_sda index ack", ack, 1'b0);
      bus_stop();
      bus_start();
      write_byte({row.addr, 1'b1}, ack);
      check_value("i2c_sda read address ack", ack, 1'b0);
      for (i = 0; i < row.len; i++) begin
         read_byte(data);
         @(negedge RST);
         check_value("i2c_read_busy", i2c_read_busy, 1'b1);
         check_value("i2c_sda read data", data, expected_read(row.index + i));
         @(posedge RST);
         write_bit(i == row.len - 1);  // nack on the last byte
      end
      bus_stop();
      t = 0;
      @(negedge RST);
      while (i2c_read_busy && t < WAIT_LIMIT) begin
         @(negedge RST);
         t++;
      end
      if (i2c_read_busy)
         report_timeout("i2c_read_busy to fall after the read");
      @(posedge RST);
   endtask

   task automatic watch_control(input logic [15:0] exp_word);
      int t;
      int hold;
      t = 0;
      @(negedge RST);
      while (cfg.control == 16'h0 && t < WAIT_LIMIT) begin
         @(negedge RST);
         t++;
      end
      if (cfg.control == 16'h0) begin
         report_timeout("cfg.control to become nonzero");
      end else begin
         check_value("cfg.control", cfg.control, {16'h0, exp_word});
         hold = 0;
         while (cfg.control != 16'h0 && hold < WAIT_LIMIT) begin
            @(negedge RST);
            hold++;
         end
         if (cfg.control != 16'h0)
            report_timeout("cfg.control to return to zero");
         else
            check_value("cfg.control hold cycles", hold, CTRL_HOLD_CYCLES + 1);
      end
   endtask

   // each control byte shows up as its own short pulse
   task automatic ctrl_op(input row_t row);
      fork
         write_op(row);
         begin
            watch_control({8'h00, row.data[7:0]});
            watch_control({row.data[15:8], 8'h00});
         end
      join
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int r;
      SCL     = 1'b1;
      scl_drv = 1'b1;
      sda_drv = 1'b1;
      sense   = '0;
      clear_m = 1'b0;
      for (r = 0; r < 14; r++)
         set_m[r] = 8'h00;

      stim[0] = '{op_write, TARGET_ADDR, 8'd0,  5'd14, 1'b1, 1'b0, 32'h0};
      stim[1] = '{op_read,  TARGET_ADDR, 8'd0,  5'd14, 1'b0, 1'b0, 32'h0};
      stim[2] = '{op_write, 7'h22,       8'd0,  5'd2,  1'b1, 1'b1, 32'h0};
      stim[3] = '{op_read,  TARGET_ADDR, 8'd18, 5'd5,  1'b0, 1'b0, 32'h0};
      stim[4] = '{op_ctrl,  TARGET_ADDR, 8'd18, 5'd2,  1'b0, 1'b0, 32'h0000_c35a};
      stim[5] = '{op_write, TARGET_ADDR, 8'd20, 5'd1,  1'b0, 1'b0, 32'h0000_0001};
      stim[6] = '{op_write, TARGET_ADDR, 8'd15, 5'd1,  1'b0, 1'b0, 32'h0000_00a5};
      stim[7] = '{op_read,  TARGET_ADDR, 8'd15, 5'd1,  1'b0, 1'b0, 32'h0};

      repeat (4) @(posedge RST);
      SCL   <= 1'b0;
      sense <= '{adc_data_value: 16'hbeef, status: 8'h3c, monitor_status: 8'h81};

      @(negedge RST);
      check_cfg();
      check_value("i2c_sda_oe", i2c_sda_oe, 1'b0);
      check_value("i2c_read_busy", i2c_read_busy, 1'b0);
      @(posedge RST);

      for (r = 0; r < NUM_ROWS; r++) begin
         case (stim[r].op)
            op_write: write_op(stim[r]);
            op_read:  read_op(stim[r]);
            default:  ctrl_op(stim[r]);
         endcase
         @(negedge RST);
         check_cfg();  // refused or spare writes leave cfg alone
         @(posedge RST);
      end

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
i2c_pkg.sv
regmap_pkg.sv
i2c_bus_sampler.sv
i2c_bit_counter.sv
i2c_byte_shifter.sv
i2c_target_fsm.sv
ctrl_regfile.sv
openwater_i2c.sv
tb_openwater_i2c_assert.sv
tb_openwater_i2c.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_openwater_i2c
FILELIST = sources.f

BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
